// File: tb.f
common/cpuPkg.sv
hdl/regFile.sv
hdl/decoder.sv
hdl/dataMem.sv
ifu/fetchUnit.sv
exu/execUnit.sv
hdl/cpuTop.sv
tests/cpuTop_assertions.sv
tests/cpuTb.sv

// File: tests/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb import cpuPkg::*;;

    localparam int PROG_LEN      = 44;
    localparam int RUN_LIMIT     = 4000;
    localparam int STALL_LIMIT   = 40;
    localparam int RETIRES_TOTAL = 36;

    // program starts at address 0 with one word per 4 bytes
    localparam logic [31:0] PROGRAM [PROG_LEN] = '{
        // addi x1, addi x2, add, sub
        32'h00500093, 32'hFFD00113, 32'h002081B3, 32'h40208233,
        // and, or, xor, slli x8 by 33
        32'h0020F2B3, 32'h0020E333, 32'h0020C3B3, 32'h02109413,
        // srai, srli by 60, slt, sltu
        32'h40115493, 32'h03C15513, 32'h001125B3, 32'h00113633,
        // lui, auipc, addi base 0x100, sd x7
        32'h123456B7, 32'h00001717, 32'h10000793, 32'h0077B023,
        // ld, sw x1 at +8, lw, sb x2 at +17
        32'h0007B803, 32'h0017A423, 32'h0087A883, 32'h002788A3,
        // lbu, lw upper half, beq taken, skipped
        32'h0117C903, 32'h0047A983, 32'h00108463, 32'h00100A13,
        // bne not taken, addi x21, blt taken, skipped
        32'h00109463, 32'h00200A93, 32'h00114463, 32'h00300A13,
        // beq not taken, blt not taken, bne taken, skipped
        32'h00208463, 32'h0020C463, 32'h00209463, 32'h00400A13,
        // jal x22, skipped, addi x23 = 0xa0, jalr x24 to 0xa1 with bit 0 cleared
        32'h00800B6F, 32'h00500A13, 32'h0A000B93, 32'h001B8C67,
        // jalr skips these
        32'h00600A13, 32'h00600A13, 32'h00600A13, 32'h00600A13,
        // illegal word, write to x0, addi x25, ebreak
        32'hFFFFFFFF, 32'h00700013, 32'h00100C93, 32'h00100073
    };

    // register contents after the program for x0 to x31
    localparam logic [63:0] EXPECTED [32] = '{
        64'h0, 64'h5, 64'hFFFFFFFFFFFFFFFD, 64'h2,
        64'h8, 64'h5, 64'hFFFFFFFFFFFFFFFD, 64'hFFFFFFFFFFFFFFF8,
        64'hA00000000, 64'hFFFFFFFFFFFFFFFE, 64'hF, 64'h1,
        64'h0, 64'h12345000, 64'h1034, 64'h100,
        64'hFFFFFFFFFFFFFFF8, 64'h5, 64'hFD, 64'hFFFFFFFFFFFFFFFF,
        64'h0, 64'h2, 64'h84, 64'hA0,
        64'h90, 64'h1, 64'h0, 64'h0,
        64'h0, 64'h0, 64'h0, 64'h0
    };

    logic        clk;
    logic        rstN_i;
    logic        fetchReqValid_o;
    fetchReqT    fetchReq_o;
    logic        fetchReqReady_i;
    logic        fetchRspValid_i;
    fetchRspT    fetchRsp_i;
    logic        fetchRspReady_o;
    logic        retireValid_o;
    retireT      retire_o;
    logic        halted_o;
    logic [31:0] lfsr;
    logic [63:0] shadow [32];
    int          retires;

    cpuTop #(.RESET_PC(64'd0)) uut (
        .clk(clk), .rstN_i(rstN_i),
        .fetchReqValid_o(fetchReqValid_o), .fetchReq_o(fetchReq_o),
        .fetchReqReady_i(fetchReqReady_i),
        .fetchRspValid_i(fetchRspValid_i), .fetchRsp_i(fetchRsp_i),
        .fetchRspReady_o(fetchRspReady_o),
        .retireValid_o(retireValid_o), .retire_o(retire_o), .halted_o(halted_o)
    );

    bind cpuTop cpuTop_assertions cpuChecks (
        .clk(clk), .rstN_i(rstN_i),
        .reqValid_i(fetchReqValid_o), .req_i(fetchReq_o), .reqReady_i(fetchReqReady_i),
        .rspValid_i(fetchRspValid_i), .rspReady_i(fetchRspReady_o),
        .retireValid_i(retireValid_o), .retire_i(retire_o),
        .nextPc_i(nextPc), .halted_i(halted_o)
    );

    always #10 clk = ~clk;

    // Galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic randBit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 32'h80200003;
        end
        return lsb;
    endfunction

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // instruction memory model that runs until the core halts
    task automatic runProgram();
        int          cycles;
        int          idle;
        int          delay;
        logic        pending;
        logic        reqFire;
        logic        rspFire;
        logic [63:0] reqAddr;
        logic [63:0] pendAddr;
        cycles   = 0;
        idle     = 0;
        delay    = 0;
        pending  = 1'b0;
        pendAddr = '0;
        @(negedge clk);
        while (!halted_o) begin
            reqFire = fetchReqValid_o && fetchReqReady_i;
            rspFire = fetchRspValid_i && fetchRspReady_o;
            reqAddr = fetchReq_o.addr;
            if (retireValid_o) begin
                retires++;
                idle = 0;
                if (retire_o.regWrite) begin
                    shadow[retire_o.rd] = retire_o.wdata;
                end
            end else begin
                idle++;
            end
            cycles++;
            if (cycles > RUN_LIMIT) begin
                stopWithFailure("timeout: the core did not halt");
            end
            if (idle > STALL_LIMIT) begin
                stopWithFailure("timeout: no instruction retired for too long");
            end
            @(posedge clk);
            #1;
            fetchReqReady_i = randBit();
            if (rspFire) begin
                fetchRspValid_i = 1'b0;
                pending         = 1'b0;
            end
            if (reqFire) begin
                if (reqAddr[1:0] != 2'b00 || reqAddr >= 64'(4 * PROG_LEN)) begin
                    stopWithFailure("the core fetched from outside the program");
                end
                pending  = 1'b1;
                pendAddr = reqAddr;
                delay    = int'(randBit()) << 1;
                delay    = delay | int'(randBit());
            end
            if (pending && !fetchRspValid_i) begin
                if (delay == 0) begin
                    fetchRspValid_i = 1'b1;
                    fetchRsp_i.inst = PROGRAM[pendAddr[63:2]];
                end else begin
                    delay--;
                end
            end
            @(negedge clk);
        end
    endtask

    task automatic checkRegisters();
        if (retires != RETIRES_TOTAL) begin
            stopWithFailure($sformatf("[ERROR] %0t: %0d instructions retired, expected %0d",
                                      $time, retires, RETIRES_TOTAL));
        end
        for (int r = 1; r < 32; r++) begin
            if (shadow[r] !== EXPECTED[r]) begin
                stopWithFailure($sformatf("[ERROR] %0t: x%0d is %h, expected %h",
                                          $time, r, shadow[r], EXPECTED[r]));
            end
        end
    endtask

    // stop as soon as a bound assertion has failed
    always @(negedge clk) begin
        if (uut.cpuChecks.failCount != 0) begin
            stopWithFailure("a bound assertion failed");
        end
    end

    initial begin
        clk             = 1'b0;
        rstN_i          = 1'b0;
        fetchReqReady_i = 1'b0;
        fetchRspValid_i = 1'b0;
        fetchRsp_i      = '0;
        lfsr            = 32'h38df3fc3;
        retires         = 0;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rstN_i = 1'b1;
        runProgram();
        // a few idle cycles so the halt checks see the parked core
        repeat (4) @(negedge clk);
        checkRegisters();
        if (uut.cpuChecks.failCount != 0) begin
            stopWithFailure("a bound assertion failed");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tests/cpuTop_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop_assertions import cpuPkg::*; (
    input  wire logic        clk,
    input  wire logic        rstN_i,
    input  wire logic        reqValid_i,
    input  wire fetchReqT    req_i,
    input  wire logic        reqReady_i,
    input  wire logic        rspValid_i,
    input  wire logic        rspReady_i,
    input  wire logic        retireValid_i,
    input  wire retireT      retire_i,
    input  wire logic [63:0] nextPc_i,
    input  wire logic        halted_i
);

    int          failCount = 0;
    logic [63:0] expPcQ;
    logic        seenRetire;
    logic        isControl;

    // jumps and branches may leave the sequential path
    assign isControl = !retire_i.illegal
                       && (retire_i.inst[6:0] == OPC_JAL
                           || retire_i.inst[6:0] == OPC_JALR
                           || retire_i.inst[6:0] == OPC_BRANCH);

    // next PC promised by the previous retire
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            seenRetire <= 1'b0;
            expPcQ     <= '0;
        end else if (retireValid_i) begin
            seenRetire <= 1'b1;
            expPcQ     <= nextPc_i;
        end
    end

    reqHeld: assert property (@(posedge clk) disable iff (!rstN_i)
        reqValid_i && !reqReady_i |=> reqValid_i && $stable(req_i))
        else begin
            failCount++;
            $error("fetch request dropped or changed before it was accepted");
        end

    pcFollows: assert property (@(posedge clk) disable iff (!rstN_i)
        retireValid_i && seenRetire |-> retire_i.pc == expPcQ)
        else begin
            failCount++;
            $error("retired PC does not follow the previous next PC");
        end

    pcSequential: assert property (@(posedge clk) disable iff (!rstN_i)
        retireValid_i && !isControl |-> nextPc_i == retire_i.pc + 64'd4)
        else begin
            failCount++;
            $error("non-control instruction did not continue at PC+4");
        end

    noWriteX0: assert property (@(posedge clk) disable iff (!rstN_i)
        retireValid_i && (retire_i.rd == 5'd0 || retire_i.illegal) |-> !retire_i.regWrite)
        else begin
            failCount++;
            $error("retire reports a register write to x0 or from an illegal word");
        end

    retireTiming: assert property (@(posedge clk) disable iff (!rstN_i)
        retireValid_i == $past(rspValid_i && rspReady_i))
        else begin
            failCount++;
            $error("retire pulse not exactly one cycle after the response handshake");
        end

    haltSticky: assert property (@(posedge clk) disable iff (!rstN_i)
        halted_i |=> halted_i)
        else begin
            failCount++;
            $error("halted output dropped");
        end

    haltNoFetch: assert property (@(posedge clk) disable iff (!rstN_i)
        halted_i |-> !reqValid_i)
        else begin
            failCount++;
            $error("fetch request issued after halt");
        end

endmodule

`default_nettype wire

// File: hdl/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop import cpuPkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC   = '0,
    parameter int              DMEM_BYTES = 4096
) (
    input  wire logic     clk,
    input  wire logic     rstN_i,
    output logic          fetchReqValid_o,
    output fetchReqT      fetchReq_o,
    input  wire logic     fetchReqReady_i,
    input  wire logic     fetchRspValid_i,
    input  wire fetchRspT fetchRsp_i,
    output logic          fetchRspReady_o,
    output logic          retireValid_o,
    output retireT        retire_o,
    output logic          halted_o
);

    logic        instValid;
    logic [31:0] inst;
    logic [63:0] pc;
    decodedT     dec;
    logic [63:0] rdata1;
    logic [63:0] rdata2;
    logic        regWe;
    logic [4:0]  regWaddr;
    logic [63:0] regWdata;
    logic [63:0] memAddr;
    logic [63:0] memWdata;
    logic [7:0]  memStrb;
    logic        memWe;
    logic [63:0] memRdata;
    logic        redirectValid;
    logic [63:0] nextPc;

    fetchUnit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .rstN_i(rstN_i),
        .fetchReqValid_o(fetchReqValid_o), .fetchReq_o(fetchReq_o),
        .fetchReqReady_i(fetchReqReady_i),
        .fetchRspValid_i(fetchRspValid_i), .fetchRsp_i(fetchRsp_i),
        .fetchRspReady_o(fetchRspReady_o),
        .redirectValid_i(redirectValid), .nextPc_i(nextPc), .halt_i(halted_o),
        .instValid_o(instValid), .inst_o(inst), .pc_o(pc)
    );

    decoder u_dec (.inst_i(inst), .dec_o(dec));

    regFile u_rf (
        .clk(clk), .rs1_i(dec.rs1), .rs2_i(dec.rs2),
        .rdata1_o(rdata1), .rdata2_o(rdata2),
        .we_i(regWe), .waddr_i(regWaddr), .wdata_i(regWdata)
    );

    execUnit u_exec (
        .clk(clk), .rstN_i(rstN_i),
        .instValid_i(instValid), .inst_i(inst), .pc_i(pc), .dec_i(dec),
        .rdata1_i(rdata1), .rdata2_i(rdata2),
        .regWe_o(regWe), .regWaddr_o(regWaddr), .regWdata_o(regWdata),
        .memAddr_o(memAddr), .memWdata_o(memWdata), .memStrb_o(memStrb),
        .memWe_o(memWe), .memRdata_i(memRdata),
        .redirectValid_o(redirectValid), .nextPc_o(nextPc),
        .retireValid_o(retireValid_o), .retire_o(retire_o), .halted_o(halted_o)
    );

    dataMem #(.DMEM_BYTES(DMEM_BYTES)) u_dmem (
        .clk(clk), .addr_i(memAddr), .wdata_i(memWdata),
        .strb_i(memStrb), .we_i(memWe), .rdata_o(memRdata)
    );

endmodule

`default_nettype wire

// File: exu/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit import cpuPkg::*; (
    input  wire logic        clk,
    input  wire logic        rstN_i,
    input  wire logic        instValid_i,
    input  wire logic [31:0] inst_i,
    input  wire logic [63:0] pc_i,
    input  wire decodedT     dec_i,
    input  wire logic [63:0] rdata1_i,
    input  wire logic [63:0] rdata2_i,
    output logic             regWe_o,
    output logic [4:0]       regWaddr_o,
    output logic [63:0]      regWdata_o,
    output logic [63:0]      memAddr_o,
    output logic [63:0]      memWdata_o,
    output logic [7:0]       memStrb_o,
    output logic             memWe_o,
    input  wire logic [63:0] memRdata_i,
    output logic             redirectValid_o,
    output logic [63:0]      nextPc_o,
    output logic             retireValid_o,
    output retireT           retire_o,
    output logic             halted_o
);

    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] aluRes;
    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] loadShifted;
    logic [XLEN-1:0] loadData;
    logic [XLEN-1:0] wbData;
    logic [2:0]      byteOff;
    logic            taken;
    logic            haltedQ;

    assign opA = dec_i.aSelPc ? pc_i : rdata1_i;
    assign opB = dec_i.bSelImm ? dec_i.imm : rdata2_i;

    always_comb begin
        case (dec_i.aluOp)
            ALU_SUB:   aluRes = opA - opB;
            ALU_AND:   aluRes = opA & opB;
            ALU_OR:    aluRes = opA | opB;
            ALU_XOR:   aluRes = opA ^ opB;
            ALU_SLL:   aluRes = opA << opB[5:0];
            ALU_SRL:   aluRes = opA >> opB[5:0];
            ALU_SRA:   aluRes = $signed(opA) >>> opB[5:0];
            ALU_SLT:   aluRes = {63'd0, $signed(opA) < $signed(opB)};
            ALU_SLTU:  aluRes = {63'd0, opA < opB};
            ALU_PASSB: aluRes = opB;
            default:   aluRes = opA + opB;
        endcase
    end

    // branch condition straight from funct3
    always_comb begin
        case (dec_i.funct3)
            3'b000:  taken = rdata1_i == rdata2_i;
            3'b001:  taken = rdata1_i != rdata2_i;
            3'b100:  taken = $signed(rdata1_i) < $signed(rdata2_i);
            3'b101:  taken = $signed(rdata1_i) >= $signed(rdata2_i);
            3'b110:  taken = rdata1_i < rdata2_i;
            3'b111:  taken = rdata1_i >= rdata2_i;
            default: taken = 1'b0;
        endcase
    end

    assign pcPlus4 = pc_i + 64'd4;

    always_comb begin
        if (dec_i.isJalr) begin
            nextPc_o = (rdata1_i + dec_i.imm) & ~64'd1;
        end else if (dec_i.isJal || (dec_i.isBranch && taken)) begin
            nextPc_o = pc_i + dec_i.imm;
        end else begin
            nextPc_o = pcPlus4;
        end
    end

    // stores replicate the data across the double word and strobe the lanes
    assign byteOff = aluRes[2:0];

    always_comb begin
        case (dec_i.memSize)
            MEM_BYTE: begin
                memStrb_o  = 8'b0000_0001 << byteOff;
                memWdata_o = {8{rdata2_i[7:0]}};
            end
            MEM_WORD: begin
                memStrb_o  = 8'b0000_1111 << {byteOff[2], 2'b00};
                memWdata_o = {2{rdata2_i[31:0]}};
            end
            default: begin
                memStrb_o  = 8'hff;
                memWdata_o = rdata2_i;
            end
        endcase
    end

    assign loadShifted = memRdata_i >> {byteOff, 3'b000};

    always_comb begin
        case (dec_i.memSize)
            MEM_BYTE: begin
                loadData = dec_i.loadUnsigned ? {56'd0, loadShifted[7:0]}
                                              : {{56{loadShifted[7]}}, loadShifted[7:0]};
            end
            MEM_WORD: begin
                loadData = dec_i.loadUnsigned ? {32'd0, loadShifted[31:0]}
                                              : {{32{loadShifted[31]}}, loadShifted[31:0]};
            end
            default: loadData = loadShifted;
        endcase
    end

    always_comb begin
        case (dec_i.wbSrc)
            WB_MEM:  wbData = loadData;
            WB_PC4:  wbData = pcPlus4;
            default: wbData = aluRes;
        endcase
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            haltedQ <= 1'b0;
        end else if (instValid_i && dec_i.isHalt) begin
            haltedQ <= 1'b1;
        end
    end

    assign memAddr_o  = aluRes;
    assign memWe_o    = instValid_i && dec_i.isStore;
    assign regWe_o    = instValid_i && dec_i.regWrite;
    assign regWaddr_o = dec_i.rd;
    assign regWdata_o = wbData;

    // ebreak gets no redirect and so parks the fetch unit
    assign redirectValid_o = instValid_i && !dec_i.isHalt;
    assign retireValid_o   = instValid_i;
    assign retire_o        = '{pc: pc_i, inst: inst_i, rd: dec_i.rd, wdata: wbData,
                               regWrite: dec_i.regWrite, illegal: dec_i.illegal};
    assign halted_o        = haltedQ;

endmodule

`default_nettype wire

// File: ifu/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import cpuPkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  wire logic        clk,
    input  wire logic        rstN_i,
    output logic             fetchReqValid_o,
    output fetchReqT         fetchReq_o,
    input  wire logic        fetchReqReady_i,
    input  wire logic        fetchRspValid_i,
    input  wire fetchRspT    fetchRsp_i,
    output logic             fetchRspReady_o,
    input  wire logic        redirectValid_i,
    input  wire logic [63:0] nextPc_i,
    input  wire logic        halt_i,
    output logic             instValid_o,
    output logic [31:0]      inst_o,
    output logic [63:0]      pc_o
);

    // IDLE is both the post-reset state and the parking state after a halt
    typedef enum logic [1:0] {IDLE, REQUEST, WAIT_RSP, EXECUTE} fetchStateE;

    fetchStateE state;
    fetchStateE stateNext;
    logic [63:0] pcQ;
    logic [31:0] instQ;

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (!halt_i) begin
                    stateNext = REQUEST;
                end
            end
            REQUEST: begin
                if (fetchReqReady_i) begin
                    stateNext = WAIT_RSP;
                end
            end
            WAIT_RSP: begin
                if (fetchRspValid_i) begin
                    stateNext = EXECUTE;
                end
            end
            // no redirect means the instruction halted the core
            EXECUTE: stateNext = redirectValid_i ? REQUEST : IDLE;
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            state <= IDLE;
            pcQ   <= RESET_PC;
        end else begin
            state <= stateNext;
            if (state == EXECUTE && redirectValid_i) begin
                pcQ <= nextPc_i;
            end
        end
    end

    // instruction word captured on the response handshake
    always_ff @(posedge clk) begin
        if (state == WAIT_RSP && fetchRspValid_i) begin
            instQ <= fetchRsp_i.inst;
        end
    end

    assign fetchReqValid_o = (state == REQUEST);
    assign fetchReq_o.addr = pcQ;
    assign fetchRspReady_o = (state == WAIT_RSP);
    assign instValid_o     = (state == EXECUTE);
    assign inst_o          = instQ;
    assign pc_o            = pcQ;

endmodule

`default_nettype wire

// File: hdl/dataMem.sv
`timescale 1ns/1ps
`default_nettype none

module dataMem #(
    parameter int DMEM_BYTES = 4096
) (
    input  wire logic        clk,
    input  wire logic [63:0] addr_i,
    input  wire logic [63:0] wdata_i,
    input  wire logic [7:0]  strb_i,
    input  wire logic        we_i,
    output logic [63:0]      rdata_o
);

    localparam int AW = $clog2(DMEM_BYTES);

    logic [7:0]    mem [DMEM_BYTES];
    logic [AW-1:0] base;

    // aligned double word, upper address bits dropped so accesses wrap
    assign base = {addr_i[AW-1:3], 3'b000};

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            rdata_o[8*i +: 8] = mem[base + AW'(i)];
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int i = 0; i < 8; i++) begin
                if (strb_i[i]) begin
                    mem[base + AW'(i)] <= wdata_i[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder import cpuPkg::*; (
    input  wire logic [31:0] inst_i,
    output decodedT          dec_o
);

    localparam logic [31:0] EBREAK = 32'h0010_0073;

    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [63:0] immI;
    logic [63:0] immS;
    logic [63:0] immB;
    logic [63:0] immU;
    logic [63:0] immJ;

    function automatic aluOpE aluFromFunct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // sign-extended immediates
    assign immI = {{52{inst_i[31]}}, inst_i[31:20]};
    assign immS = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign immB = {{51{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign immU = {{32{inst_i[31]}}, inst_i[31:12], 12'd0};
    assign immJ = {{43{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21],
                   1'b0};

    always_comb begin
        dec_o              = '0;
        dec_o.rs1          = inst_i[19:15];
        dec_o.rs2          = inst_i[24:20];
        dec_o.rd           = inst_i[11:7];
        dec_o.funct3       = funct3;
        dec_o.aluOp        = ALU_ADD;
        dec_o.wbSrc        = WB_ALU;
        dec_o.memSize      = MEM_BYTE;
        dec_o.loadUnsigned = funct3[2];
        case (opcodeE'(inst_i[6:0]))
            OPC_OP: begin
                dec_o.aluOp    = aluFromFunct(funct3, inst_i[30]);
                dec_o.regWrite = 1'b1;
                dec_o.illegal  = !(funct7 == 7'h00
                                   || (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            OPC_OP_IMM: begin
                // only srai has the alternate bit, shamt takes six bits on RV64
                dec_o.aluOp    = aluFromFunct(funct3, funct3 == 3'b101 && inst_i[30]);
                dec_o.imm      = immI;
                dec_o.bSelImm  = 1'b1;
                dec_o.regWrite = 1'b1;
                if (funct3 == 3'b001) begin
                    dec_o.illegal = inst_i[31:26] != 6'b000000;
                end else if (funct3 == 3'b101) begin
                    dec_o.illegal = inst_i[31:26] != 6'b000000 && inst_i[31:26] != 6'b010000;
                end
            end
            OPC_LUI: begin
                dec_o.aluOp    = ALU_PASSB;
                dec_o.imm      = immU;
                dec_o.bSelImm  = 1'b1;
                dec_o.regWrite = 1'b1;
            end
            OPC_AUIPC: begin
                dec_o.imm      = immU;
                dec_o.aSelPc   = 1'b1;
                dec_o.bSelImm  = 1'b1;
                dec_o.regWrite = 1'b1;
            end
            OPC_JAL: begin
                dec_o.imm      = immJ;
                dec_o.isJal    = 1'b1;
                dec_o.regWrite = 1'b1;
                dec_o.wbSrc    = WB_PC4;
            end
            OPC_JALR: begin
                dec_o.imm      = immI;
                dec_o.isJalr   = 1'b1;
                dec_o.regWrite = 1'b1;
                dec_o.wbSrc    = WB_PC4;
                dec_o.illegal  = funct3 != 3'b000;
            end
            OPC_BRANCH: begin
                dec_o.imm      = immB;
                dec_o.isBranch = 1'b1;
                dec_o.illegal  = funct3 == 3'b010 || funct3 == 3'b011;
            end
            OPC_LOAD: begin
                // ld, lw and lbu only
                dec_o.imm      = immI;
                dec_o.bSelImm  = 1'b1;
                dec_o.isLoad   = 1'b1;
                dec_o.regWrite = 1'b1;
                dec_o.wbSrc    = WB_MEM;
                dec_o.illegal  = !(funct3 == 3'b011 || funct3 == 3'b010 || funct3 == 3'b100);
                if (!dec_o.illegal) begin
                    dec_o.memSize = memSizeE'(funct3[1:0]);
                end
            end
            OPC_STORE: begin
                dec_o.imm     = immS;
                dec_o.bSelImm = 1'b1;
                dec_o.isStore = 1'b1;
                dec_o.illegal = !(funct3 == 3'b000 || funct3 == 3'b010 || funct3 == 3'b011);
                if (!dec_o.illegal) begin
                    dec_o.memSize = memSizeE'(funct3[1:0]);
                end
            end
            OPC_SYSTEM: begin
                dec_o.isHalt  = inst_i == EBREAK;
                dec_o.illegal = inst_i != EBREAK;
            end
            default: dec_o.illegal = 1'b1;
        endcase

        // an illegal word retires as a no-op
        if (dec_o.illegal) begin
            dec_o.isBranch = 1'b0;
            dec_o.isJal    = 1'b0;
            dec_o.isJalr   = 1'b0;
            dec_o.isLoad   = 1'b0;
            dec_o.isStore  = 1'b0;
            dec_o.isHalt   = 1'b0;
        end
        if (dec_o.illegal || dec_o.rd == 5'd0) begin
            dec_o.regWrite = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire logic        clk,
    input  wire logic [4:0]  rs1_i,
    input  wire logic [4:0]  rs2_i,
    output logic [63:0]      rdata1_o,
    output logic [63:0]      rdata2_o,
    input  wire logic        we_i,
    input  wire logic [4:0]  waddr_i,
    input  wire logic [63:0] wdata_i
);

    logic [63:0] regs [32];

    // x0 reads as zero whatever the array holds
    assign rdata1_o = (rs1_i == 5'd0) ? 64'd0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == 5'd0) ? 64'd0 : regs[rs2_i];

    always_ff @(posedge clk) begin
        if (we_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

// File: common/cpuPkg.sv
`default_nettype none

package cpuPkg;

    parameter int XLEN = 64;
    parameter int ILEN = 32;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_SYSTEM = 7'b1110011
    } opcodeE;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASSB
    } aluOpE;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wbSrcE;

    // matches funct3[1:0] of the load/store encodings
    typedef enum logic [1:0] {
        MEM_BYTE   = 2'b00,
        MEM_WORD   = 2'b10,
        MEM_DOUBLE = 2'b11
    } memSizeE;

    typedef struct packed {
        logic [XLEN-1:0] addr;
    } fetchReqT;

    typedef struct packed {
        logic [ILEN-1:0] inst;
    } fetchRspT;

    typedef struct packed {
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [XLEN-1:0] imm;
        aluOpE           aluOp;
        logic            aSelPc;
        logic            bSelImm;
        logic            regWrite;
        logic            isBranch;
        logic            isJal;
        logic            isJalr;
        logic            isLoad;
        logic            isStore;
        logic            isHalt;
        logic            illegal;
        logic [2:0]      funct3;
        memSizeE         memSize;
        logic            loadUnsigned;
        wbSrcE           wbSrc;
    } decodedT;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [ILEN-1:0] inst;
        logic [4:0]      rd;
        logic [XLEN-1:0] wdata;
        logic            regWrite;
        logic            illegal;
    } retireT;

endpackage

`default_nettype wire
